// ==== run.sh ====
#!/bin/bash
# Build and run with Verilator, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f vlog.f -o cpuSim \
   > build.log 2>&1 \
   && ./obj_dir/cpuSim > sim.log 2>&1 \
   || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
   || grep -q "Test completed successfully" sim.log \
   || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
exit 0

// ==== source/cpuAlu.sv ====
`timescale 1ns/100ps

module cpuAlu (
   input  cpuPkg::dataT  a,
   input  cpuPkg::dataT  b,
   input  cpuPkg::aluOpT op,
   output cpuPkg::dataT  result
);

   // Pure combinational, result settles within the cycle the opcode is on romData
   always_comb begin
      unique case (op)
         // Arithmetic wraps at 8 bits
         cpuPkg::ALU_ADD:   result = a + b;
         cpuPkg::ALU_SUB:   result = a - b;
         cpuPkg::ALU_INC_A: result = a + cpuPkg::dataT'(1);

         // Bitwise logic
         cpuPkg::ALU_AND:   result = a & b;
         cpuPkg::ALU_OR:    result = a | b;
         cpuPkg::ALU_XOR:   result = a ^ b;

         // Single bit shifts of A, zero fill
         cpuPkg::ALU_SHL:   result = a << 1;
         cpuPkg::ALU_SHR:   result = a >> 1;

         // Compares give one or zero
         // Unsigned, used by the branch through aluTrue
         cpuPkg::ALU_EQ:    result = cpuPkg::dataT'(a == b);
         cpuPkg::ALU_GT:    result = cpuPkg::dataT'(a > b);
         cpuPkg::ALU_LT:    result = cpuPkg::dataT'(a < b);

         // Unused codes
         default:           result = '0;
      endcase
   end

endmodule

// ==== source/cpuControl.sv ====
`timescale 1ns/100ps

module cpuControl (
   input  logic                          CLK,
   input  logic                          RESET,
   input  cpuPkg::dataT                  romData,
   input  logic                          aluTrue,
   input  logic [cpuPkg::IRQ_COUNT-1:0]  irqRaise,
   output logic [cpuPkg::IRQ_COUNT-1:0]  irqAck,
   output cpuPkg::addrT                  romAddr,
   output cpuPkg::dpCtrlT                dpCtrl,
   output cpuPkg::aluOpT                 aluOp
);

   // Sequencer state
   cpuPkg::cpuStateT state;
   cpuPkg::cpuStateT nextState;

   // Program counter plus operand offset forms the ROM address
   cpuPkg::addrT     pc;
   cpuPkg::addrT     nextPc;
   cpuPkg::pcOffsetT pcOffset;
   cpuPkg::pcOffsetT nextPcOffset;

   // Register chosen by a read or write, 1 for B
   logic regSelect;
   logic nextRegSelect;

   logic [cpuPkg::IRQ_COUNT-1:0] nextIrqAck;

   // Instruction class sits in the low nibble
   cpuPkg::opcodeT opcode;

   assign opcode  = romData[3:0];
   assign aluOp   = romData[7:4];
   assign romAddr = pc + cpuPkg::addrT'(pcOffset);

   ////////////////////////////////////////////////////////////////////////////
   // State registers

   always_ff @(posedge CLK) begin
      if (RESET) begin
         state     <= cpuPkg::CHOOSE_OP;
         pc        <= '0;
         pcOffset  <= '0;
         regSelect <= 1'b0;
         irqAck    <= '0;
      end else begin
         state     <= nextState;
         pc        <= nextPc;
         pcOffset  <= nextPcOffset;
         regSelect <= nextRegSelect;
         irqAck    <= nextIrqAck;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Next state and program counter

   always_comb begin
      // Hold by default, offset falls back to zero
      nextState     = state;
      nextPc        = pc;
      nextPcOffset  = '0;
      nextRegSelect = regSelect;
      nextIrqAck    = '0;

      unique case (state)
         // Wait for an interrupt, line 0 wins
         cpuPkg::IDLE: begin
            nextPc = cpuPkg::VECTOR_IRQ0;
            if (irqRaise[0]) begin
               nextState     = cpuPkg::THREAD_START_0;
               nextIrqAck[0] = 1'b1;
            end else if (irqRaise[1]) begin
               nextState     = cpuPkg::THREAD_START_0;
               nextPc        = cpuPkg::VECTOR_IRQ1;
               nextIrqAck[1] = 1'b1;
            end
         end
         // Vector address on romAddr
         cpuPkg::THREAD_START_0: nextState = cpuPkg::THREAD_START_1;
         // Vector content arrives, becomes the thread start
         cpuPkg::THREAD_START_1: begin
            nextState = cpuPkg::THREAD_START_2;
            nextPc    = romData;
         end
         // First instruction fetch in flight
         cpuPkg::THREAD_START_2: nextState = cpuPkg::CHOOSE_OP;

         // Decode, operand byte fetched next cycle when legal
         cpuPkg::CHOOSE_OP: begin
            nextPcOffset = 2'd1;
            case (opcode)
               cpuPkg::OP_READ_A:  nextState = cpuPkg::READ_TO_A;
               cpuPkg::OP_READ_B:  nextState = cpuPkg::READ_TO_B;
               cpuPkg::OP_WRITE_A: nextState = cpuPkg::WRITE_FROM_A;
               cpuPkg::OP_WRITE_B: nextState = cpuPkg::WRITE_FROM_B;
               cpuPkg::OP_MATH_A:  nextState = cpuPkg::MATH_SAVE_A;
               cpuPkg::OP_MATH_B:  nextState = cpuPkg::MATH_SAVE_B;
               cpuPkg::OP_BRANCH:  nextState = cpuPkg::BRANCH;
               cpuPkg::OP_GOTO:    nextState = cpuPkg::GOTO;
               cpuPkg::OP_IDLE: begin
                  nextState = cpuPkg::IDLE;
                  nextPc    = cpuPkg::VECTOR_IRQ0;
               end
               // Illegal opcode, stay put
               default:            nextPcOffset = '0;
            endcase
         end

         ///////////////////////////////////////////////////////////////////////
         // Memory read, address byte follows the instruction
         cpuPkg::READ_TO_A: begin
            nextState     = cpuPkg::READ_0;
            nextRegSelect = 1'b0;
         end
         cpuPkg::READ_TO_B: begin
            nextState     = cpuPkg::READ_0;
            nextRegSelect = 1'b1;
         end
         // Address byte on romData, datapath registers it
         cpuPkg::READ_0: nextState = cpuPkg::READ_1;
         // Step past operand so the next opcode is ready in time
         cpuPkg::READ_1: begin
            nextState = cpuPkg::READ_2;
            nextPc    = pc + 8'd2;
         end
         // Read data lands in the register
         cpuPkg::READ_2: nextState = cpuPkg::CHOOSE_OP;

         ///////////////////////////////////////////////////////////////////////
         // Memory write
         cpuPkg::WRITE_FROM_A: begin
            nextState     = cpuPkg::WRITE_0;
            nextRegSelect = 1'b0;
            nextPc        = pc + 8'd2;
         end
         cpuPkg::WRITE_FROM_B: begin
            nextState     = cpuPkg::WRITE_0;
            nextRegSelect = 1'b1;
            nextPc        = pc + 8'd2;
         end
         cpuPkg::WRITE_0: nextState = cpuPkg::CHOOSE_OP;

         // ALU result saved this cycle
         cpuPkg::MATH_SAVE_A,
         cpuPkg::MATH_SAVE_B: begin
            nextState = cpuPkg::MATH_0;
            nextPc    = pc + 8'd1;
         end
         cpuPkg::MATH_0: nextState = cpuPkg::CHOOSE_OP;

         ///////////////////////////////////////////////////////////////////////
         // Branch on compare, target byte follows the instruction
         cpuPkg::BRANCH: begin
            if (aluTrue) begin
               nextState = cpuPkg::BRANCH_0;
            end else begin
               nextState = cpuPkg::BRANCH_1;
               nextPc    = pc + 8'd2;
            end
         end
         cpuPkg::BRANCH_0: begin
            nextState = cpuPkg::BRANCH_1;
            nextPc    = romData;
         end
         cpuPkg::BRANCH_1: nextState = cpuPkg::CHOOSE_OP;

         // Unconditional jump
         cpuPkg::GOTO:   nextState = cpuPkg::GOTO_0;
         cpuPkg::GOTO_0: begin
            nextState = cpuPkg::GOTO_1;
            nextPc    = romData;
         end
         cpuPkg::GOTO_1: nextState = cpuPkg::CHOOSE_OP;

         default: nextState = cpuPkg::CHOOSE_OP;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Datapath controls, decoded from the current state only

   always_comb begin
      dpCtrl            = '0;
      dpCtrl.writeFromB = regSelect;
      unique case (state)
         cpuPkg::READ_0:      dpCtrl.busAddrLoad = 1'b1;
         cpuPkg::READ_2: begin
            dpCtrl.loadA = ~regSelect;
            dpCtrl.loadB = regSelect;
         end
         cpuPkg::WRITE_0: begin
            dpCtrl.busAddrLoad = 1'b1;
            dpCtrl.busWrite    = 1'b1;
         end
         cpuPkg::MATH_SAVE_A: begin
            dpCtrl.loadA   = 1'b1;
            dpCtrl.fromAlu = 1'b1;
         end
         cpuPkg::MATH_SAVE_B: begin
            dpCtrl.loadB   = 1'b1;
            dpCtrl.fromAlu = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// ==== source/cpuDatapath.sv ====
`timescale 1ns/100ps

module cpuDatapath (
   input  logic            CLK,
   input  logic            RESET,
   input  cpuPkg::dpCtrlT  dpCtrl,
   input  cpuPkg::aluOpT   aluOp,
   input  cpuPkg::dataT    romData,
   input  cpuPkg::dataT    busRdData,
   output cpuPkg::busReqT  busReq,
   output logic            aluTrue
);

   // Working registers
   cpuPkg::dataT regA;
   cpuPkg::dataT regB;

   // ALU result and the value selected for a register load
   cpuPkg::dataT aluResult;
   cpuPkg::dataT loadValue;

   // Registered bus request
   cpuPkg::addrT busAddrQ;
   cpuPkg::dataT busWrDataQ;
   logic         busWeQ;

   cpuAlu alu (
      .a      (regA),
      .b      (regB),
      .op     (aluOp),
      .result (aluResult)
   );

   // Nonzero result drives the branch decision
   assign aluTrue = |aluResult;

   // Math ops load from the ALU, reads load from the bus
   assign loadValue = dpCtrl.fromAlu ? aluResult : busRdData;

   ////////////////////////////////////////////////////////////////////////////
   // Registers A and B

   always_ff @(posedge CLK) begin
      if (RESET) begin
         regA <= '0;
         regB <= '0;
      end else begin
         if (dpCtrl.loadA) begin
            regA <= loadValue;
         end
         if (dpCtrl.loadB) begin
            regB <= loadValue;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus request registers

   // Address comes straight from the operand byte on romData
   // Parks at the idle address otherwise
   always_ff @(posedge CLK) begin
      if (RESET) begin
         busAddrQ <= cpuPkg::BUS_IDLE_ADDR;
         busWeQ   <= 1'b0;
      end else begin
         busAddrQ <= dpCtrl.busAddrLoad ? romData : cpuPkg::BUS_IDLE_ADDR;
         busWeQ   <= dpCtrl.busWrite;
      end
   end

   // Write data captured together with the write strobe
   always_ff @(posedge CLK) begin
      if (dpCtrl.busWrite) begin
         busWrDataQ <= dpCtrl.writeFromB ? regB : regA;
      end
   end

   assign busReq = '{addr: busAddrQ, wrData: busWrDataQ, we: busWeQ};

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Word types

   // Data and register word
   typedef logic [7:0] dataT;
   // Data bus and ROM address
   typedef logic [7:0] addrT;
   // Offset added to the program counter for operand fetch
   typedef logic [1:0] pcOffsetT;
   // Instruction class, low nibble of an instruction byte
   typedef logic [3:0] opcodeT;
   // ALU function, high nibble of an instruction byte
   typedef logic [3:0] aluOpT;

   ////////////////////////////////////////////////////////////////////////////
   // Opcodes, 9 to 15 are illegal

   localparam opcodeT OP_READ_A  = 4'd0;
   localparam opcodeT OP_READ_B  = 4'd1;
   localparam opcodeT OP_WRITE_A = 4'd2;
   localparam opcodeT OP_WRITE_B = 4'd3;
   localparam opcodeT OP_MATH_A  = 4'd4;
   localparam opcodeT OP_MATH_B  = 4'd5;
   localparam opcodeT OP_BRANCH  = 4'd6;
   localparam opcodeT OP_GOTO    = 4'd7;
   localparam opcodeT OP_IDLE    = 4'd8;

   // ALU functions
   localparam aluOpT ALU_ADD   = 4'd0;
   localparam aluOpT ALU_SUB   = 4'd1;
   localparam aluOpT ALU_AND   = 4'd2;
   localparam aluOpT ALU_OR    = 4'd3;
   localparam aluOpT ALU_XOR   = 4'd4;
   localparam aluOpT ALU_SHL   = 4'd5;
   localparam aluOpT ALU_SHR   = 4'd6;
   localparam aluOpT ALU_INC_A = 4'd7;
   localparam aluOpT ALU_EQ    = 4'd8;
   localparam aluOpT ALU_GT    = 4'd9;
   localparam aluOpT ALU_LT    = 4'd10;

   // ROM locations holding the thread start addresses
   localparam addrT VECTOR_IRQ0 = 8'hFF;
   localparam addrT VECTOR_IRQ1 = 8'hFE;

   // Bus address parked here when no access is running
   localparam addrT BUS_IDLE_ADDR = 8'hFF;

   localparam int IRQ_COUNT = 2;

   ////////////////////////////////////////////////////////////////////////////
   // Sequencer states and grouped signals

   typedef enum logic [4:0] {
      IDLE,
      THREAD_START_0,
      THREAD_START_1,
      THREAD_START_2,
      CHOOSE_OP,
      READ_TO_A,
      READ_TO_B,
      READ_0,
      READ_1,
      READ_2,
      WRITE_FROM_A,
      WRITE_FROM_B,
      WRITE_0,
      MATH_SAVE_A,
      MATH_SAVE_B,
      MATH_0,
      BRANCH,
      BRANCH_0,
      BRANCH_1,
      GOTO,
      GOTO_0,
      GOTO_1
   } cpuStateT;

   // Outgoing data memory request
   typedef struct packed {
      addrT addr;
      dataT wrData;
      logic we;
   } busReqT;

   // Sequencer to datapath controls
   typedef struct packed {
      logic loadA;
      logic loadB;
      logic fromAlu;
      logic busAddrLoad;
      logic busWrite;
      logic writeFromB;
   } dpCtrlT;

endpackage

// ==== source/cpuTop.sv ====
`timescale 1ns/100ps

module cpuTop (
   input  logic                          CLK,
   input  logic                          RESET,
   // Program ROM
   output cpuPkg::addrT                  romAddr,
   input  cpuPkg::dataT                  romData,
   // Data memory bus
   output cpuPkg::busReqT                busReq,
   input  cpuPkg::dataT                  busRdData,
   // Interrupt lines
   input  logic [cpuPkg::IRQ_COUNT-1:0]  irqRaise,
   output logic [cpuPkg::IRQ_COUNT-1:0]  irqAck
);

   // Sequencer to datapath
   cpuPkg::dpCtrlT dpCtrl;
   cpuPkg::aluOpT  aluOp;

   // Compare result back to the sequencer
   logic aluTrue;

   cpuControl control (
      .CLK      (CLK),
      .RESET    (RESET),
      .romData  (romData),
      .aluTrue  (aluTrue),
      .irqRaise (irqRaise),
      .irqAck   (irqAck),
      .romAddr  (romAddr),
      .dpCtrl   (dpCtrl),
      .aluOp    (aluOp)
   );

   cpuDatapath datapath (
      .CLK       (CLK),
      .RESET     (RESET),
      .dpCtrl    (dpCtrl),
      .aluOp     (aluOp),
      .romData   (romData),
      .busRdData (busRdData),
      .busReq    (busReq),
      .aluTrue   (aluTrue)
   );

endmodule

// ==== verification/cpuChk.sv ====
`timescale 1ns/100ps

module cpuChk (
   input logic                          CLK,
   input logic                          RESET,
   input cpuPkg::busReqT                busReq,
   input logic [cpuPkg::IRQ_COUNT-1:0]  irqAck
);

   // One line acknowledged at a time, for a single cycle
   ackOneHot: assert property (@(posedge CLK) disable iff (RESET) $onehot0(irqAck))
      else $error("irqAck has more than one bit set");
   ackPulse: assert property (@(posedge CLK) disable iff (RESET)
      (irqAck != '0) |=> (irqAck == '0))
      else $error("irqAck held for two cycles");

   // Write strobe is a single cycle pulse
   wePulse: assert property (@(posedge CLK) disable iff (RESET) busReq.we |=> !busReq.we)
      else $error("busReq.we held for two cycles");

   // Access address lasts one cycle, then the bus parks again
   addrPark: assert property (@(posedge CLK) disable iff (RESET)
      (busReq.addr != cpuPkg::BUS_IDLE_ADDR) |=> (busReq.addr == cpuPkg::BUS_IDLE_ADDR))
      else $error("busReq.addr not parked after an access");

endmodule

bind cpuTop cpuChk chk (
   .CLK    (CLK),
   .RESET  (RESET),
   .busReq (busReq),
   .irqAck (irqAck)
);

// ==== verification/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb;

   localparam int CLK_PERIOD = 20;
   // Cycle bound of one wait, and how many waits and resets the tests use at most
   localparam int WAIT_BOUND = 200;
   localparam int WAIT_TOTAL = 46;

   logic                         CLK;
   logic                         RESET;
   cpuPkg::addrT                 romAddr;
   cpuPkg::dataT                 romData;
   cpuPkg::busReqT               busReq;
   cpuPkg::dataT                 busRdData;
   logic [cpuPkg::IRQ_COUNT-1:0] irqRaise;
   logic [cpuPkg::IRQ_COUNT-1:0] irqAck;

   // Memory models
   cpuPkg::dataT rom [0:255];
   cpuPkg::dataT ram [0:255];
   cpuPkg::addrT romAddrQ;
   cpuPkg::addrT busAddrQ;

   int writeCount;
   int errorCount;
   int checkCount;
   integer seed;

   cpuTop DUT (
      .CLK       (CLK),
      .RESET     (RESET),
      .romAddr   (romAddr),
      .romData   (romData),
      .busReq    (busReq),
      .busRdData (busRdData),
      .irqRaise  (irqRaise),
      .irqAck    (irqAck)
   );

   initial begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   ////////////////////////////////////////////////////////////////////////////
   // ROM and RAM models with one cycle read latency

   // Addresses and writes taken at the rising edge
   always @(posedge CLK) begin
      romAddrQ = romAddr;
      busAddrQ = busReq.addr;
      if (busReq.we) begin
         ram[busReq.addr] = busReq.wrData;
         writeCount = writeCount + 1;
      end
   end

   // Read data driven on the falling edge
   always @(negedge CLK) begin
      romData   <= rom[romAddrQ];
      busRdData <= ram[busAddrQ];
   end

   // Run time limit
   initial begin
      #(WAIT_TOTAL * (WAIT_BOUND + 20) * CLK_PERIOD);
      $display("Error: watchdog expired before the tests finished");
      $display("Test failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic checkByte(input string name, input logic [7:0] got,
                            input logic [7:0] exp);
      checkCount = checkCount + 1;
      assert (got === exp) else begin
         errorCount = errorCount + 1;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Fill depends on the whole address and every ROM opcode nibble is OP_IDLE
   task automatic fillMemories();
      for (int i = 0; i < 256; i++) begin
         rom[i] = {i[3:0] ^ i[7:4], cpuPkg::OP_IDLE};
         ram[i] = i[7:0] ^ 8'h5A;
      end
   endtask

   task automatic applyReset();
      @(negedge CLK);
      RESET    = 1'b1;
      irqRaise = '0;
      repeat (10) @(negedge CLK);
      writeCount = 0;
      RESET      = 1'b0;
   endtask

   task automatic waitWrites(input int count);
      int cycles;
      cycles = 0;
      while (writeCount < count && cycles < WAIT_BOUND) begin
         @(negedge CLK);
         cycles = cycles + 1;
      end
      assert (writeCount >= count) else begin
         errorCount = errorCount + 1;
         $display("Error: only %0d of %0d bus writes seen in time", writeCount, count);
      end
   endtask

   function automatic logic [7:0] randomByte();
      int r;
      r = $random(seed);
      return r[7:0];
   endfunction

   // Operation table of the ALU
   function automatic logic [7:0] aluExpected(input logic [3:0] op,
                                              input logic [7:0] a, input logic [7:0] b);
      case (op)
         4'd0:    return a + b;
         4'd1:    return a - b;
         4'd2:    return a & b;
         4'd3:    return a | b;
         4'd4:    return a ^ b;
         4'd5:    return {a[6:0], 1'b0};
         4'd6:    return {1'b0, a[7:1]};
         4'd7:    return a + 8'd1;
         4'd8:    return (a == b) ? 8'd1 : 8'd0;
         4'd9:    return (a > b) ? 8'd1 : 8'd0;
         4'd10:   return (a < b) ? 8'd1 : 8'd0;
         default: return 8'd0;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic resetValues();
      fillMemories();
      applyReset();
      checkByte("busReq.we", {7'd0, busReq.we}, 8'h00);
      checkByte("irqAck", {6'd0, irqAck}, 8'h00);
      checkByte("romAddr", romAddr, 8'h00);
   endtask

   task automatic copyBytes();
      logic [7:0] x;
      logic [7:0] y;
      fillMemories();
      x = randomByte();
      y = randomByte();
      ram[8'h10] = x;
      ram[8'h11] = y;
      rom[8'h00] = {4'h0, cpuPkg::OP_READ_A};
      rom[8'h01] = 8'h10;
      rom[8'h02] = {4'h0, cpuPkg::OP_READ_B};
      rom[8'h03] = 8'h11;
      rom[8'h04] = {4'h0, cpuPkg::OP_WRITE_A};
      rom[8'h05] = 8'h20;
      rom[8'h06] = {4'h0, cpuPkg::OP_WRITE_B};
      rom[8'h07] = 8'h21;
      rom[8'h08] = {4'h0, cpuPkg::OP_IDLE};
      applyReset();
      waitWrites(2);
      checkByte("ram[20]", ram[8'h20], x);
      checkByte("ram[21]", ram[8'h21], y);
   endtask

   // Even codes save in A, odd codes in B
   task automatic aluOps();
      logic [7:0] x;
      logic [7:0] y;
      logic [3:0] op;
      for (int i = 0; i < 12; i++) begin
         op = i[3:0];
         fillMemories();
         x = randomByte();
         y = (op == cpuPkg::ALU_EQ) ? x : randomByte();
         ram[8'h10] = x;
         ram[8'h11] = y;
         rom[8'h00] = {4'h0, cpuPkg::OP_READ_A};
         rom[8'h01] = 8'h10;
         rom[8'h02] = {4'h0, cpuPkg::OP_READ_B};
         rom[8'h03] = 8'h11;
         rom[8'h04] = {op, op[0] ? cpuPkg::OP_MATH_B : cpuPkg::OP_MATH_A};
         rom[8'h05] = {4'h0, op[0] ? cpuPkg::OP_WRITE_B : cpuPkg::OP_WRITE_A};
         rom[8'h06] = 8'h30;
         rom[8'h07] = {4'h0, cpuPkg::OP_IDLE};
         applyReset();
         waitWrites(1);
         checkByte($sformatf("ram[30] op %0d", op), ram[8'h30], aluExpected(op, x, y));
      end
   endtask

   task automatic branchCase(input logic [3:0] op, input logic [7:0] x, input logic [7:0] y);
      logic taken;
      fillMemories();
      taken = aluExpected(op, x, y) != 8'd0;
      ram[8'h10] = x;
      ram[8'h11] = y;
      ram[8'h12] = 8'hA1;
      ram[8'h13] = 8'hB2;
      ram[8'h14] = 8'hC3;
      rom[8'h00] = {4'h0, cpuPkg::OP_READ_A};
      rom[8'h01] = 8'h10;
      rom[8'h02] = {4'h0, cpuPkg::OP_READ_B};
      rom[8'h03] = 8'h11;
      rom[8'h04] = {op, cpuPkg::OP_BRANCH};
      rom[8'h05] = 8'h20;
      // Fall through path
      rom[8'h06] = {4'h0, cpuPkg::OP_READ_A};
      rom[8'h07] = 8'h12;
      rom[8'h08] = {4'h0, cpuPkg::OP_WRITE_A};
      rom[8'h09] = 8'h40;
      rom[8'h0A] = {4'h0, cpuPkg::OP_IDLE};
      // Branch target, then a goto
      rom[8'h20] = {4'h0, cpuPkg::OP_READ_A};
      rom[8'h21] = 8'h13;
      rom[8'h22] = {4'h0, cpuPkg::OP_WRITE_A};
      rom[8'h23] = 8'h41;
      rom[8'h24] = {4'h0, cpuPkg::OP_GOTO};
      rom[8'h25] = 8'h30;
      rom[8'h30] = {4'h0, cpuPkg::OP_READ_A};
      rom[8'h31] = 8'h14;
      rom[8'h32] = {4'h0, cpuPkg::OP_WRITE_A};
      rom[8'h33] = 8'h42;
      rom[8'h34] = {4'h0, cpuPkg::OP_IDLE};
      applyReset();
      waitWrites(taken ? 2 : 1);
      // Let any stray write land
      repeat (20) @(negedge CLK);
      checkByte("ram[40]", ram[8'h40], taken ? (8'h40 ^ 8'h5A) : 8'hA1);
      checkByte("ram[41]", ram[8'h41], taken ? 8'hB2 : (8'h41 ^ 8'h5A));
      checkByte("ram[42]", ram[8'h42], taken ? 8'hC3 : (8'h42 ^ 8'h5A));
   endtask

   task automatic branchesAndGoto();
      logic [7:0] x;
      logic [7:0] y;
      logic [7:0] hi;
      logic [7:0] lo;
      x = randomByte();
      y = randomByte();
      if (x == y) begin
         y = x ^ 8'h01;
      end
      hi = (x > y) ? x : y;
      lo = (x > y) ? y : x;
      branchCase(cpuPkg::ALU_EQ, x, x);
      branchCase(cpuPkg::ALU_EQ, x, y);
      branchCase(cpuPkg::ALU_GT, hi, lo);
      branchCase(cpuPkg::ALU_GT, lo, hi);
      branchCase(cpuPkg::ALU_LT, lo, hi);
      branchCase(cpuPkg::ALU_LT, hi, lo);
   endtask

   task automatic irqCase(input logic [1:0] lines, input logic [1:0] expAck);
      int cycles;
      logic [1:0] ack;
      ram[8'h90] = 8'h90 ^ 8'h5A;
      ram[8'h91] = 8'h91 ^ 8'h5A;
      writeCount = 0;
      @(negedge CLK);
      irqRaise = lines;
      cycles   = 0;
      while (irqAck == '0 && cycles < WAIT_BOUND) begin
         @(negedge CLK);
         cycles = cycles + 1;
      end
      ack      = irqAck;
      irqRaise = '0;
      checkByte("irqAck", {6'd0, ack}, {6'd0, expAck});
      waitWrites(1);
      repeat (8) @(negedge CLK);
      checkByte("ram[90]", ram[8'h90], expAck[0] ? 8'hD4 : (8'h90 ^ 8'h5A));
      checkByte("ram[91]", ram[8'h91], expAck[1] ? 8'hE5 : (8'h91 ^ 8'h5A));
   endtask

   task automatic interruptThreads();
      fillMemories();
      rom[8'h00] = {4'h0, cpuPkg::OP_IDLE};
      rom[cpuPkg::VECTOR_IRQ0] = 8'h40;
      rom[cpuPkg::VECTOR_IRQ1] = 8'h60;
      ram[8'h80] = 8'hD4;
      ram[8'h81] = 8'hE5;
      // Each thread writes its marker and goes idle again
      rom[8'h40] = {4'h0, cpuPkg::OP_READ_A};
      rom[8'h41] = 8'h80;
      rom[8'h42] = {4'h0, cpuPkg::OP_WRITE_A};
      rom[8'h43] = 8'h90;
      rom[8'h44] = {4'h0, cpuPkg::OP_IDLE};
      rom[8'h60] = {4'h0, cpuPkg::OP_READ_B};
      rom[8'h61] = 8'h81;
      rom[8'h62] = {4'h0, cpuPkg::OP_WRITE_B};
      rom[8'h63] = 8'h91;
      rom[8'h64] = {4'h0, cpuPkg::OP_IDLE};
      applyReset();
      repeat (5) @(negedge CLK);
      irqCase(2'b01, 2'b01);
      irqCase(2'b10, 2'b10);
      irqCase(2'b11, 2'b01);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Sequence and report

   initial begin
      RESET      = 1'b1;
      irqRaise   = '0;
      romData    = '0;
      busRdData  = '0;
      romAddrQ   = '0;
      busAddrQ   = '0;
      writeCount = 0;
      errorCount = 0;
      checkCount = 0;
      seed       = 17;
      resetValues();
      copyBytes();
      aluOps();
      branchesAndGoto();
      interruptThreads();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
source/cpuPkg.sv
source/cpuAlu.sv
source/cpuDatapath.sv
source/cpuControl.sv
source/cpuTop.sv
verification/cpuChk.sv
verification/cpuTb.sv
